/* flist.f */
fruPkg.sv
fruInputLatch.sv
fruMirrorPipe.sv
fruRegFile.sv
fruOperandMux.sv
fru.sv
tb_fru.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_fru -f flist.f
	out="$$(./obj_dir/Vtb_fru 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* tb_fru.sv */
// testbench for the forwarding register unit
// reference model of latch, mirror pipe and register file with directed and random stimulus

`timescale 1ns/1ps

module tb_fru;
   import fruPkg::*;

   localparam int randomCycles = 2000;
   localparam int maxCycles    = 2500;   // reset + ~80 directed + random plus margin

   typedef struct packed {
      dataT opd1;
      dataT opd2;
      logic waitData;
   } expectT;

   logic        sys_clk = 1'b0;
   logic        rst;
   pipeCtrlT    ctrl;
   regAddrT     regA, regB;
   decodeT      decode;
   stageResultT exuRes, mauRes;
   dataT        opd1, opd2;
   logic        waitForData;

   // reference state shaped like the unit
   pipeCtrlT    refCtrl;
   regAddrT     refRegA, refRegB;
   decodeT      refDecode;
   stageResultT refExu, refMau, refWb;
   logic        refLoad;
   dataT        refRegs [numRegs];

   int    seed       = 32'h5ba919d6;
   int    cycleCount = 0;
   logic  checkEn    = 1'b0;
   string testName   = "reset";

   fru u_dut (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .ctrl        (ctrl),
      .regA        (regA),
      .regB        (regB),
      .decode      (decode),
      .exuRes      (exuRes),
      .mauRes      (mauRes),
      .opd1        (opd1),
      .opd2        (opd2),
      .waitForData (waitForData)
   );

   always #4 sys_clk = ~sys_clk;   // 8 ns period

   ////////////////////////////////////////
   // reporting
   ////////////////////////////////////////
   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic valueMismatch(input string sig, input dataT expVal, input dataT actVal);
      failRun($sformatf("error in test %s: %s expected %h actual %h",
                        testName, sig, expVal, actVal));
   endtask

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   // forwarding priority exu, mau, wb, then register file
   function automatic dataT pickOperand(input regAddrT src);
      if (src.idx == zeroRegIdx) return '0;          // r31 always zero
      if (src.valid) begin
         if (refExu.dest == src && refCtrl.workExu && refExu.cond && !refLoad) return refExu.data;
         if (refMau.dest == src && refCtrl.workMau && refMau.cond) return refMau.data;
         if (refWb.dest == src && refCtrl.workWb && refWb.cond) return refWb.data;
      end
      return refRegs[src.idx];
   endfunction

   // stall when the source waits on a load still in execute whatever its cond
   function automatic logic loadWait(input regAddrT src);
      return src.valid && (src.idx != zeroRegIdx) && (refExu.dest == src)
             && refCtrl.workExu && refLoad;
   endfunction

   function automatic expectT expectedOutputs();
      expectT e;
      e.opd1     = pickOperand(refRegA);
      e.opd2     = pickOperand(refRegB);
      e.waitData = loadWait(refRegA) | loadWait(refRegB);
      return e;
   endfunction

   // inputs only change 1 ns after the edge, so they are stable here
   always @(posedge sys_clk) begin
      if (rst) begin
         {refCtrl, refRegA, refRegB, refDecode} = '0;
         {refExu, refMau, refWb, refLoad} = '0;
         for (int i = 0; i < numRegs; i++) refRegs[i] = '0;
      end else begin
         // commit first since it uses the old wb entry
         if (refCtrl.workWb && refWb.cond && refWb.dest.valid)
            refRegs[refWb.dest.idx] = refWb.data;
         if (refCtrl.stepExu)
            refLoad = refDecode.mem && refDecode.memAcc && !refDecode.memSt;
         if (refCtrl.stepWb) refWb = refMau;
         refCtrl   = ctrl;
         refRegA   = regA;
         refRegB   = regB;
         refDecode = decode;
         refExu    = exuRes;
         refMau    = mauRes;
      end
   end

   // outputs are settled mid cycle well before the next drive
   always @(negedge sys_clk) begin : compare
      expectT want;
      if (checkEn) begin
         want = expectedOutputs();
         assert (opd1 === want.opd1) else valueMismatch("opd1", want.opd1, opd1);
         assert (opd2 === want.opd2) else valueMismatch("opd2", want.opd2, opd2);
         assert (waitForData === want.waitData)
            else valueMismatch("waitForData", {31'b0, want.waitData}, {31'b0, waitForData});
      end
   end

   always @(posedge sys_clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= maxCycles)
         failRun($sformatf("timeout: run did not finish within %0d cycles", maxCycles));
   end

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   task automatic nextCycle();
      @(posedge sys_clk);
      #1;                                            // drive just after the edge
   endtask

   function automatic regAddrT addr(input logic valid, input logic [idxWidth-1:0] idx);
      return regAddrT'({valid, idx});
   endfunction

   function automatic stageResultT result(input logic valid, input logic [idxWidth-1:0] idx,
                                          input dataT data, input logic cond);
      return stageResultT'({valid, idx, data, cond});
   endfunction

   // small index pool so addresses collide often
   function automatic logic [idxWidth-1:0] pickIdx(input logic [1:0] sel);
      case (sel)
         2'd0:    return 5'd2;
         2'd1:    return 5'd6;
         2'd2:    return 5'd13;
         default: return zeroRegIdx;
      endcase
   endfunction

   // ctrl bits are {stepExu, stepMau, stepWb, workExu, workMau, workWb}
   task automatic writeBack(input logic [idxWidth-1:0] idx, input dataT data);
      mauRes = result(1'b1, idx, data, 1'b1);
      ctrl   = 6'b001001;                            // step into wb
      nextCycle();
      mauRes = '0;
      ctrl   = 6'b000001;                            // commit at the following edge
      nextCycle();
      ctrl   = '0;
   endtask

   task automatic randomInputs();
      logic [31:0] r;
      r      = $random(seed);
      ctrl   = r[5:0];
      decode = r[8:6];
      regA   = addr(r[9] | r[10], pickIdx(r[12:11]));   // mostly valid
      regB   = addr(r[13] | r[14], pickIdx(r[16:15]));
      exuRes = result(r[17] | r[18], pickIdx(r[20:19]), $random(seed), r[21] | r[22]);
      mauRes = result(r[23] | r[24], pickIdx(r[26:25]), $random(seed), r[27] | r[28]);
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      rst    = 1'b1;
      ctrl   = '0;
      regA   = '0;
      regB   = '0;
      decode = '0;
      exuRes = '0;
      mauRes = '0;
      repeat (2) @(posedge sys_clk);
      #1;
      rst     = 1'b0;
      checkEn = 1'b1;
      nextCycle();                                   // reset state checked here

      testName = "write back";
      for (int i = 0; i < 8; i++) writeBack(idxWidth'(i * 4), 32'hC0DE_0000 + i);
      testName = "register read";
      for (int i = 0; i < 8; i++) begin
         regA = addr(1'b1, idxWidth'(i * 4));
         regB = addr(1'b1, idxWidth'(28 - i * 4));
         nextCycle();
      end

      testName = "priority";
      for (int k = 0; k < 8; k++) begin
         regA   = addr(1'b1, 5'd7);
         regB   = addr(1'b1, 5'd7);
         mauRes = result(1'b1, 5'd7, 32'hB0B0_0000 + k, 1'b1);
         ctrl   = 6'b001000;                         // wb entry for r7
         nextCycle();
         exuRes = result(1'b1, 5'd7, 32'hE0E0_0000 + k, k[0]);
         mauRes = result(1'b1, 5'd7, 32'hA0A0_0000 + k, 1'b1);
         ctrl   = {3'b000, 1'b1, k[1], k[2]};
         nextCycle();
         nextCycle();
      end

      testName = "register 31";
      writeBack(zeroRegIdx, 32'h3131_3131);          // stored r31 must never show
      exuRes = result(1'b1, zeroRegIdx, 32'hDEAD_BEEF, 1'b1);
      mauRes = result(1'b1, zeroRegIdx, 32'h1234_5678, 1'b1);
      ctrl   = 6'b000111;
      regA   = addr(1'b1, zeroRegIdx);
      regB   = addr(1'b0, zeroRegIdx);
      nextCycle();
      testName = "invalid source";
      exuRes = result(1'b0, 5'd4, 32'hDEAD_BEEF, 1'b1);
      mauRes = result(1'b0, 5'd4, 32'h1234_5678, 1'b1);
      regA   = addr(1'b0, 5'd4);
      regB   = addr(1'b0, 5'd8);
      nextCycle();
      nextCycle();

      testName = "load hazard";
      decode = 3'b110;                               // load enters execute
      ctrl   = 6'b100000;
      nextCycle();
      decode = '0;
      ctrl   = 6'b000110;
      exuRes = result(1'b1, 5'd12, 32'h0BAD_F00D, 1'b1);
      mauRes = result(1'b1, 5'd12, 32'h600D_0001, 1'b1);
      regA   = addr(1'b1, 5'd12);
      regB   = addr(1'b1, 5'd16);
      nextCycle();
      mauRes = result(1'b1, 5'd20, 32'h600D_0002, 1'b1);   // falls back to the register file
      nextCycle();
      regA   = addr(1'b1, 5'd16);
      regB   = addr(1'b1, 5'd12);
      nextCycle();
      decode = 3'b111;                               // a store clears the load flag
      ctrl   = 6'b100110;
      nextCycle();
      ctrl   = 6'b000110;
      nextCycle();
      nextCycle();

      testName = "random";
      repeat (randomCycles) begin
         randomInputs();
         nextCycle();
      end

      ctrl   = '0;
      exuRes = '0;
      mauRes = '0;
      nextCycle();
      @(negedge sys_clk);
      #1;
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* fru.sv */
// forwarding register unit top level
// latches inputs, mirrors the pipe, holds registers and forwards two operands

`timescale 1ns/1ps

module fru (
   input  logic                sys_clk,
   input  logic                rst,
   input  fruPkg::pipeCtrlT    ctrl,        // from the control unit
   input  fruPkg::regAddrT     regA,        // from decode
   input  fruPkg::regAddrT     regB,
   input  fruPkg::decodeT      decode,
   input  fruPkg::stageResultT exuRes,      // from the execute unit
   input  fruPkg::stageResultT mauRes,      // from the memory unit
   output fruPkg::dataT        opd1,        // operand A to execute
   output fruPkg::dataT        opd2,        // operand B to execute
   output logic                waitForData  // stall request to the control unit
);
   import fruPkg::*;

   pipeCtrlT    lCtrl;
   regAddrT     lRegA, lRegB;
   decodeT      lDecode;
   stageResultT lExuRes, lMauRes;
   logic        exuIsLoad;
   stageResultT wbRes;
   dataT        rdDataA, rdDataB;
   logic        hazardA, hazardB;

   ////////////////////////////////////////
   // stage 1, input latch
   ////////////////////////////////////////
   fruInputLatch u_latch (
      .sys_clk (sys_clk),
      .rst     (rst),
      .ctrl    (ctrl),
      .regA    (regA),
      .regB    (regB),
      .decode  (decode),
      .exuRes  (exuRes),
      .mauRes  (mauRes),
      .lCtrl   (lCtrl),
      .lRegA   (lRegA),
      .lRegB   (lRegB),
      .lDecode (lDecode),
      .lExuRes (lExuRes),
      .lMauRes (lMauRes)
   );

   ////////////////////////////////////////
   // mirror pipe and register file
   ////////////////////////////////////////
   fruMirrorPipe u_mirror (
      .sys_clk   (sys_clk),
      .rst       (rst),
      .lCtrl     (lCtrl),
      .lDecode   (lDecode),
      .lMauRes   (lMauRes),
      .exuIsLoad (exuIsLoad),
      .wbRes     (wbRes)
   );

   fruRegFile u_regFile (
      .sys_clk (sys_clk),
      .rst     (rst),
      .wbRes   (wbRes),
      .workWb  (lCtrl.workWb),
      .rdIdxA  (lRegA.idx),             // read regardless of valid bit
      .rdIdxB  (lRegB.idx),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   ////////////////////////////////////////
   // operand muxes, one per source
   ////////////////////////////////////////
   fruOperandMux u_muxA (
      .src        (lRegA),
      .regData    (rdDataA),
      .lExuRes    (lExuRes),
      .lMauRes    (lMauRes),
      .wbRes      (wbRes),
      .lCtrl      (lCtrl),
      .exuIsLoad  (exuIsLoad),
      .opd        (opd1),
      .loadHazard (hazardA)
   );

   fruOperandMux u_muxB (
      .src        (lRegB),
      .regData    (rdDataB),
      .lExuRes    (lExuRes),
      .lMauRes    (lMauRes),
      .wbRes      (wbRes),
      .lCtrl      (lCtrl),
      .exuIsLoad  (exuIsLoad),
      .opd        (opd2),
      .loadHazard (hazardB)
   );

   assign waitForData = hazardA | hazardB;  // either operand needs the load

endmodule

/* fruOperandMux.sv */
// operand forwarding mux for one source register
// priority execute, memory, write-back, register file; flags a load hazard

`timescale 1ns/1ps

module fruOperandMux (
   input  fruPkg::regAddrT     src,        // latched source address
   input  fruPkg::dataT        regData,    // register file read at src.idx
   input  fruPkg::stageResultT lExuRes,
   input  fruPkg::stageResultT lMauRes,
   input  fruPkg::stageResultT wbRes,
   input  fruPkg::pipeCtrlT    lCtrl,
   input  logic                exuIsLoad,
   output fruPkg::dataT        opd,
   output logic                loadHazard  // source waits on a load in execute
);
   import fruPkg::*;

   logic isZeroReg;                        // source is register 31
   logic srcOk;                            // source may be forwarded
   logic exuHit, mauHit, wbHit;            // dest matches and stage busy
   logic takeExu, takeMau, takeWb;

   ////////////////////////////////////////
   // address compare
   ////////////////////////////////////////
   assign isZeroReg = (src.idx == zeroRegIdx);
   assign srcOk     = src.valid & ~isZeroReg;

   // struct compare covers both valid bit and index
   assign exuHit = srcOk & (lExuRes.dest == src) & lCtrl.workExu;
   assign mauHit = srcOk & (lMauRes.dest == src) & lCtrl.workMau;
   assign wbHit  = srcOk & (wbRes.dest == src) & lCtrl.workWb;

   // a load result in execute is not ready yet, skip that stage
   assign takeExu = exuHit & lExuRes.cond & ~exuIsLoad;
   assign takeMau = mauHit & lMauRes.cond;
   assign takeWb  = wbHit & wbRes.cond;

   // cond is ignored here, the stall is requested on address alone
   assign loadHazard = exuHit & exuIsLoad;

   ////////////////////////////////////////
   // operand select
   ////////////////////////////////////////
   always_comb begin
      if (isZeroReg) begin
         opd = '0;                         // r31 reads zero, valid bit or not
      end else if (takeExu) begin
         opd = lExuRes.data;
      end else if (takeMau) begin
         opd = lMauRes.data;
      end else if (takeWb) begin
         opd = wbRes.data;                 // not yet in the register file
      end else begin
         opd = regData;
      end
   end

endmodule

/* fruRegFile.sv */
// architectural register file, 32 x 32
// one synchronous write port from write-back, two combinational reads

`timescale 1ns/1ps

module fruRegFile (
   input  logic                        sys_clk,
   input  logic                        rst,
   input  fruPkg::stageResultT         wbRes,   // write-back entry
   input  logic                        workWb,  // write-back stage busy
   input  logic [fruPkg::idxWidth-1:0] rdIdxA,
   input  logic [fruPkg::idxWidth-1:0] rdIdxB,
   output fruPkg::dataT                rdDataA,
   output fruPkg::dataT                rdDataB
);
   import fruPkg::*;

   dataT regs [numRegs];                    // register storage
   logic wrEn;

   // commit only real, valid, non-squashed results
   assign wrEn = workWb & wbRes.cond & wbRes.dest.valid;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;                  // whole file zeroed in one cycle
         end
      end else if (wrEn) begin
         regs[wbRes.dest.idx] <= wbRes.data;
      end
   end

   // reads see the old value during the write cycle, write-back forwarding covers it
   assign rdDataA = regs[rdIdxA];
   assign rdDataB = regs[rdIdxB];

endmodule

/* fruMirrorPipe.sv */
// mirror of the processor pipeline inside the forwarding unit
// tracks a load in execute and holds the write-back entry

`timescale 1ns/1ps

module fruMirrorPipe (
   input  logic                sys_clk,
   input  logic                rst,
   input  fruPkg::pipeCtrlT    lCtrl,     // latched steps
   input  fruPkg::decodeT      lDecode,   // latched decode flags
   input  fruPkg::stageResultT lMauRes,   // latched memory stage result
   output logic                exuIsLoad, // instruction in execute is a load
   output fruPkg::stageResultT wbRes      // entry in write-back
);
   import fruPkg::*;

   ////////////////////////////////////////
   // execute and write-back mirror stages
   ////////////////////////////////////////
   // a clear step bit leaves the stage as it is
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         exuIsLoad <= 1'b0;
         wbRes     <= '0;
      end else begin
         if (lCtrl.stepExu) begin
            exuIsLoad <= isLoad(lDecode);   // load data only exists after memory
         end
         if (lCtrl.stepWb) begin
            wbRes <= lMauRes;               // dest, data and cond move on together
         end
      end
   end

endmodule

/* fruInputLatch.sv */
// input latch stage of the forwarding unit
// registers all control and stage inputs once per clock

`timescale 1ns/1ps

module fruInputLatch (
   input  logic                sys_clk,
   input  logic                rst,
   input  fruPkg::pipeCtrlT    ctrl,      // steps and works from the control unit
   input  fruPkg::regAddrT     regA,      // operand A source
   input  fruPkg::regAddrT     regB,      // operand B source
   input  fruPkg::decodeT      decode,    // memory flags of the decoded instruction
   input  fruPkg::stageResultT exuRes,    // execute stage result
   input  fruPkg::stageResultT mauRes,    // memory stage result
   output fruPkg::pipeCtrlT    lCtrl,
   output fruPkg::regAddrT     lRegA,
   output fruPkg::regAddrT     lRegB,
   output fruPkg::decodeT      lDecode,
   output fruPkg::stageResultT lExuRes,
   output fruPkg::stageResultT lMauRes
);
   import fruPkg::*;

   // control inputs settle late in the cycle, so everything is
   // captured here and held steady for the rest of the unit
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         lCtrl   <= '0;            // no step, no work
         lRegA   <= '0;
         lRegB   <= '0;
         lDecode <= '0;
         lExuRes <= '0;            // dest invalid, cond 0
         lMauRes <= '0;
      end else begin
         lCtrl   <= ctrl;
         lRegA   <= regA;
         lRegB   <= regB;
         lDecode <= decode;
         lExuRes <= exuRes;
         lMauRes <= mauRes;
      end
   end

endmodule

/* fruPkg.sv */
// forwarding register unit shared definitions
// widths, register 31 index and the structs passed between stages

package fruPkg;

   ////////////////////////////////////////
   // sizes
   ////////////////////////////////////////
   localparam int dataWidth = 32;              // operand and result width
   localparam int numRegs   = 32;              // register file depth
   localparam int idxWidth  = $clog2(numRegs); // register index width, 5 bits

   // register 31 always reads zero and is never a forwarding target
   localparam logic [idxWidth-1:0] zeroRegIdx = 5'd31;

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////
   typedef logic [dataWidth-1:0] dataT;        // one data word

   // register address with its valid bit on top, 6 bits
   typedef struct packed {
      logic                valid;              // 1 = address in use
      logic [idxWidth-1:0] idx;                // register number
   } regAddrT;

   // the memory flags of the instruction decode, 3 bits
   typedef struct packed {
      logic mem;                               // memory class instruction
      logic memAcc;                            // accesses memory
      logic memSt;                             // store, clear for a load
   } decodeT;

   // step and work controls from the pipeline control unit, 6 bits
   // step moves an instruction into a stage, work marks a stage as busy
   typedef struct packed {
      logic stepExu;
      logic stepMau;
      logic stepWb;
      logic workExu;
      logic workMau;
      logic workWb;
   } pipeCtrlT;

   // result bus of a pipeline stage, 39 bits
   typedef struct packed {
      regAddrT dest;                           // destination register
      dataT    data;                           // result value
      logic    cond;                           // 0 only for a false cmov
   } stageResultT;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   // load = memory access that does not store
   function automatic logic isLoad(input decodeT dec);
      return dec.mem & dec.memAcc & ~dec.memSt;
   endfunction

endpackage
